// File: design/he_macros.svh
// Sizes shared by the packages and the RTL
// The hit prescaler must be wide enough to count to HE_HITS_PER_LEVEL - 1
// Key index width must cover HE_NUM_KEYS entries
`ifndef HE_MACROS_SVH
`define HE_MACROS_SVH

// Key pixels per frame
`define HE_NUM_KEYS 8
`define HE_IDX_W 3

// Pixel and level width
`define HE_PIX_W 8

// Stream hits per output level step
`define HE_HITS_PER_LEVEL 4
`define HE_PRESCALE_W 2

// Level saturation value
`define HE_LEVEL_MAX 255

`endif

// File: design/he_pixel_pkg.sv
// Pixel and level data types
// Levels share the pixel width, so a level never exceeds HE_LEVEL_MAX
`include "he_macros.svh"

package he_pixel_pkg;

	// One input pixel
	typedef logic [`HE_PIX_W-1:0] pixel_t;

	// One equalised output level
	typedef logic [`HE_PIX_W-1:0] level_t;

	// All keys of a frame
	// entry 0 holds the first key loaded
	typedef pixel_t [`HE_NUM_KEYS-1:0] key_array_t;

	// Levels of all rank lanes, in key order
	typedef level_t [`HE_NUM_KEYS-1:0] level_array_t;

endpackage

// File: design/he_ctrl_pkg.sv
// Frame phase and control word types
// The control word is produced once in the controller and fanned out to the
// key register and every rank lane
`include "he_macros.svh"

package he_ctrl_pkg;

	// Frame phases
	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		LOAD  = 2'd1,
		ACCUM = 2'd2,
		DRAIN = 2'd3
	} he_phase_e;

	// --------------------
	// Control word
	// --------------------
	typedef struct packed {
		// Shift in_image into the key register
		logic key_shift;
		// Zero prescalers and levels
		logic lane_clear;
		// in_image is a stream pixel
		logic hit_en;
		// Lane on out_image during DRAIN
		logic [`HE_IDX_W-1:0] drain_idx;
	} he_ctrl_t;

endpackage

// File: design/he_ctrl.sv
// Frame controller
// A stream ends on the first low in_valid after the last key
// in_valid is ignored while the levels are drained
`timescale 1ns/10ps
`include "he_macros.svh"

module he_ctrl import he_ctrl_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     in_valid,
	output he_ctrl_t ctrl,
	output logic     out_valid
);

	he_phase_e phase;
	he_phase_e phase_nxt;

	// Keys loaded so far
	logic [`HE_IDX_W:0] key_cnt;
	logic [`HE_IDX_W-1:0] drain_cnt;

	logic loading;
	logic last_key;
	logic stream_end;
	logic drain_done;

	assign loading    = (phase == IDLE) || (phase == LOAD);
	assign last_key   = in_valid && (key_cnt == (`HE_IDX_W+1)'(`HE_NUM_KEYS - 1));
	assign stream_end = (phase == ACCUM) && !in_valid;
	assign drain_done = (phase == DRAIN) && (drain_cnt == (`HE_IDX_W)'(`HE_NUM_KEYS - 1));

	// --------------------
	// Next phase
	// --------------------
	always_comb begin
		phase_nxt = phase;
		case (phase)
			IDLE, LOAD: begin
				if (last_key) begin
					phase_nxt = ACCUM;
				end else if (in_valid) begin
					phase_nxt = LOAD;
				end
			end
			ACCUM: begin
				if (!in_valid) begin
					phase_nxt = DRAIN;
				end
			end
			DRAIN: begin
				if (drain_done) begin
					phase_nxt = IDLE;
				end
			end
			default: phase_nxt = IDLE;
		endcase
	end

	// --------------------
	// Phase and counters
	// --------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase     <= IDLE;
			key_cnt   <= '0;
			drain_cnt <= '0;
			out_valid <= 1'b0;
		end else begin
			phase <= phase_nxt;

			if (loading && last_key) begin
				key_cnt <= '0;
			end else if (loading && in_valid) begin
				key_cnt <= key_cnt + 1'b1;
			end

			// Drain index restarts at lane 0 for every frame
			if (stream_end) begin
				drain_cnt <= '0;
			end else if (phase == DRAIN) begin
				drain_cnt <= drain_cnt + 1'b1;
			end

			if (stream_end) begin
				out_valid <= 1'b1;
			end else if (drain_done) begin
				out_valid <= 1'b0;
			end
		end
	end

	// Control word to key register and lanes
	always_comb begin
		ctrl.key_shift  = loading && in_valid;
		ctrl.lane_clear = (phase == IDLE);
		ctrl.hit_en     = (phase == ACCUM) && in_valid;
		ctrl.drain_idx  = drain_cnt;
	end

	// out_valid only in DRAIN and never longer than one cycle per key
	a_valid_in_drain: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> (phase == DRAIN) && !$past(out_valid, `HE_NUM_KEYS));

	a_key_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
		(phase == LOAD) |-> (key_cnt <= (`HE_IDX_W+1)'(`HE_NUM_KEYS - 1)));

endmodule

// File: design/he_key_shift.sv
// Key register
// Keys enter at the top entry and move down one entry per shift
// After HE_NUM_KEYS shifts entry 0 holds the first key of the frame
`timescale 1ns/10ps
`include "he_macros.svh"

module he_key_shift
	import he_pixel_pkg::*;
	import he_ctrl_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  he_ctrl_t   ctrl,
	input  pixel_t     in_image,
	output key_array_t keys
);

	key_array_t keys_nxt;

	// Newest key enters the top and the oldest drops out of entry 0
	always_comb begin
		if (ctrl.key_shift) begin
			keys_nxt = {in_image, keys[`HE_NUM_KEYS-1:1]};
		end else begin
			keys_nxt = keys;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			keys <= '0;
		end else begin
			keys <= keys_nxt;
		end
	end

endmodule

// File: design/he_rank_lane.sv
// One rank lane
// Counts stream pixels at or below its key, one level step per
// HE_HITS_PER_LEVEL hits, holding at HE_LEVEL_MAX
`timescale 1ns/10ps
`include "he_macros.svh"

module he_rank_lane
	import he_pixel_pkg::*;
	import he_ctrl_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  he_ctrl_t ctrl,
	input  pixel_t   in_image,
	input  pixel_t   key,
	output level_t   level
);

	logic [`HE_PRESCALE_W-1:0] prescale;
	logic hit;
	logic wrap;
	logic at_max;

	assign hit    = ctrl.hit_en && (in_image <= key);
	assign wrap   = hit && (prescale == (`HE_PRESCALE_W)'(`HE_HITS_PER_LEVEL - 1));
	assign at_max = (level == (`HE_PIX_W)'(`HE_LEVEL_MAX));

	// --------------------
	// Hit prescaler
	// --------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prescale <= '0;
		end else if (ctrl.lane_clear || wrap) begin
			prescale <= '0;
		end else if (hit) begin
			prescale <= prescale + 1'b1;
		end
	end

	// --------------------
	// Saturating level
	// --------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			level <= '0;
		end else if (ctrl.lane_clear) begin
			level <= '0;
		end else if (wrap && !at_max) begin
			level <= level + 1'b1;
		end
	end

	// Only a clear may lower the level
	a_level_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
		!ctrl.lane_clear |=> (level >= $past(level)));

endmodule

// File: design/he_level_bank.sv
// Bank of rank lanes, one per key
// out_image shows lane drain_idx while out_valid is high and 0 otherwise
// Selection is combinational, so drain_idx must be stable for the cycle
`timescale 1ns/10ps
`include "he_macros.svh"

module he_level_bank
	import he_pixel_pkg::*;
	import he_ctrl_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  he_ctrl_t   ctrl,
	input  pixel_t     in_image,
	input  key_array_t keys,
	input  logic       out_valid,
	output level_t     out_image
);

	level_array_t levels;

	// --------------------
	// Rank lanes
	// --------------------
	for (genvar i = 0; i < `HE_NUM_KEYS; i++) begin : g_lane
		he_rank_lane u_lane (
			.clk      (clk),
			.rst_n    (rst_n),
			.ctrl     (ctrl),
			.in_image (in_image),
			.key      (keys[i]),
			.level    (levels[i])
		);
	end

	// --------------------
	// Drain select
	// --------------------
	always_comb begin
		if (out_valid) begin
			out_image = levels[ctrl.drain_idx];
		end else begin
			out_image = '0;
		end
	end

endmodule

// File: design/he_top.sv
// Streaming rank-to-level unit
// Valid-only protocol without back-pressure
// Eight keys, then a stream ended by a low in_valid, then eight levels out
`timescale 1ns/10ps

module he_top
	import he_pixel_pkg::*;
	import he_ctrl_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   in_valid,
	input  pixel_t in_image,
	output logic   out_valid,
	output level_t out_image
);

	he_ctrl_t   ctrl;
	key_array_t keys;

	he_ctrl u_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.ctrl      (ctrl),
		.out_valid (out_valid)
	);

	he_key_shift u_key_shift (
		.clk      (clk),
		.rst_n    (rst_n),
		.ctrl     (ctrl),
		.in_image (in_image),
		.keys     (keys)
	);

	he_level_bank u_level_bank (
		.clk       (clk),
		.rst_n     (rst_n),
		.ctrl      (ctrl),
		.in_image  (in_image),
		.keys      (keys),
		.out_valid (out_valid),
		.out_image (out_image)
	);

endmodule

// File: dv/tb_clk_gen.sv
// Free-running testbench clock, 20 ns period, starts low
`timescale 1ns/10ps

module tb_clk_gen (
	output logic clk
);

	localparam int HALF_PERIOD = 10;

	initial begin
		clk = 1'b0;
	end

	always begin
		#(HALF_PERIOD);
		clk = ~clk;
	end

endmodule

// File: dv/tb_he_top.sv
// Random frames from a fixed-seed LCG are checked against a rank-to-level model
// Inputs are driven and outputs sampled 2 ns after each rising edge
// Each drain is checked on the eight cycles right after its stream ends
`timescale 1ns/10ps
`include "he_macros.svh"

module tb_he_top
	import he_pixel_pkg::*;
();

	localparam int CLK_PERIOD        = 20;
	localparam int DRIVE_DELAY       = 2;
	localparam int RESET_CYCLES      = 8;
	localparam int NUM_RANDOM_FRAMES = 30;
	localparam int MAX_RANDOM_STREAM = 300;
	localparam int SAT_STREAM        = 1100;
	localparam int MAX_GAP           = 2;
	// reset check, random frames, empty, saturation, two back-to-back
	localparam int NUM_FRAMES        = 1 + NUM_RANDOM_FRAMES + 1 + 1 + 2;
	localparam int WATCHDOG_CYCLES   = NUM_FRAMES * (SAT_STREAM + 40) + RESET_CYCLES;

	logic   clk;
	logic   rst_n;
	logic   in_valid;
	pixel_t in_image;
	logic   out_valid;
	level_t out_image;

	int unsigned lcg_state;
	int          checks;
	int          errors;
	int          test_errors;
	int          tests_run;
	int          tests_failed;
	string       test_name;
	pixel_t      key_list [`HE_NUM_KEYS];
	level_t      exp_levels [`HE_NUM_KEYS];
	pixel_t      stream_q [$];

	tb_clk_gen u_clk_gen (
		.clk (clk)
	);

	he_top u_he_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_image  (in_image),
		.out_valid (out_valid),
		.out_image (out_image)
	);

	// --------------------
	// Random numbers and model
	// --------------------
	function automatic int unsigned next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		// Low bits of an LCG have short periods
		return lcg_state >> 16;
	endfunction

	function automatic int unsigned random_below(int unsigned n);
		return next_random() % n;
	endfunction

	function automatic pixel_t random_pixel();
		return pixel_t'(random_below(256));
	endfunction

	// One level per four stream pixels at or below the key up to the maximum
	function automatic level_t model_level(pixel_t key);
		int hits;
		int lvl;
		hits = 0;
		foreach (stream_q[i]) begin
			if (stream_q[i] <= key) begin
				hits++;
			end
		end
		lvl = hits / `HE_HITS_PER_LEVEL;
		if (lvl > `HE_LEVEL_MAX) begin
			lvl = `HE_LEVEL_MAX;
		end
		return level_t'(lvl);
	endfunction

	// --------------------
	// Bookkeeping
	// --------------------
	function automatic void note_error();
		errors++;
		test_errors++;
	endfunction

	task automatic begin_test(string name);
		test_name   = name;
		test_errors = 0;
		tests_run++;
	endtask

	task automatic end_test();
		if (test_errors == 0) begin
			$display("[%s] ok", test_name);
		end else begin
			$display("[%s] failed with %0d errors", test_name, test_errors);
			tests_failed++;
		end
	endtask

	// --------------------
	// Drive and check
	// --------------------
	task automatic step_cycle();
		@(posedge clk);
		#(DRIVE_DELAY);
	endtask

	task automatic drive_inputs(logic valid, pixel_t pixel);
		in_valid = valid;
		in_image = pixel;
	endtask

	task automatic check_quiet();
		checks++;
		assert (out_valid == 1'b0) else begin
			$display("Error in %s: out_valid is high outside the drain", test_name);
			note_error();
		end
		checks++;
		assert (out_image == '0) else begin
			$display("Mismatch in %s: out_image expected %0d actual %0d",
				test_name, 0, out_image);
			note_error();
		end
	endtask

	task automatic fill_random_keys();
		for (int k = 0; k < `HE_NUM_KEYS; k++) begin
			key_list[k] = random_pixel();
		end
	endtask

	// Gaps carry junk pixels with in_valid low
	task automatic load_keys(int unsigned max_gap);
		int unsigned gaps;
		for (int k = 0; k < `HE_NUM_KEYS; k++) begin
			gaps = random_below(max_gap + 1);
			repeat (gaps) begin
				drive_inputs(1'b0, random_pixel());
				step_cycle();
				check_quiet();
			end
			drive_inputs(1'b1, key_list[k]);
			step_cycle();
			check_quiet();
		end
	endtask

	task automatic send_stream(int unsigned length);
		pixel_t pixel;
		stream_q.delete();
		repeat (length) begin
			pixel = random_pixel();
			stream_q.push_back(pixel);
			drive_inputs(1'b1, pixel);
			step_cycle();
			check_quiet();
		end
	endtask

	// End the stream, then expect eight levels in key order
	task automatic drain_and_check(logic hold_valid);
		for (int k = 0; k < `HE_NUM_KEYS; k++) begin
			exp_levels[k] = model_level(key_list[k]);
		end
		drive_inputs(1'b0, '0);
		step_cycle();
		for (int i = 0; i < `HE_NUM_KEYS; i++) begin
			checks++;
			assert (out_valid == 1'b1) else begin
				$display("Error in %s: out_valid is low in drain cycle %0d", test_name, i);
				note_error();
			end
			checks++;
			assert (out_image == exp_levels[i]) else begin
				$display("Mismatch in %s: lane %0d expected %0d actual %0d",
					test_name, i, exp_levels[i], out_image);
				note_error();
			end
			if (hold_valid) begin
				drive_inputs(1'b1, random_pixel());
			end else begin
				drive_inputs(1'b0, '0);
			end
			step_cycle();
		end
		drive_inputs(1'b0, '0);
		check_quiet();
	endtask

	// --------------------
	// Watchdog
	// --------------------
	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

	// --------------------
	// Test sequence
	// --------------------
	initial begin : stimulus
		lcg_state    = 32'd23952;
		checks       = 0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		rst_n        = 1'b0;
		in_valid     = 1'b0;
		in_image     = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#(DRIVE_DELAY);
		rst_n = 1'b1;

		begin_test("reset_idle");
		repeat (10) begin
			drive_inputs(1'b0, random_pixel());
			step_cycle();
			check_quiet();
		end
		fill_random_keys();
		load_keys(MAX_GAP);
		send_stream(20);
		drain_and_check(1'b0);
		end_test();

		begin_test("random_frames");
		repeat (NUM_RANDOM_FRAMES) begin
			fill_random_keys();
			load_keys(MAX_GAP);
			send_stream(random_below(MAX_RANDOM_STREAM + 1));
			drain_and_check(1'b0);
		end
		end_test();

		begin_test("empty_stream");
		fill_random_keys();
		load_keys(MAX_GAP);
		send_stream(0);
		drain_and_check(1'b0);
		end_test();

		begin_test("saturation");
		for (int k = 0; k < `HE_NUM_KEYS; k++) begin
			key_list[k] = '1;
		end
		load_keys(MAX_GAP);
		send_stream(SAT_STREAM);
		drain_and_check(1'b0);
		end_test();

		// Junk on in_valid through the first drain and the second frame loads at once
		begin_test("drain_back_to_back");
		fill_random_keys();
		load_keys(MAX_GAP);
		send_stream(100 + random_below(100));
		drain_and_check(1'b1);
		fill_random_keys();
		load_keys(0);
		send_stream(random_below(MAX_RANDOM_STREAM + 1));
		drain_and_check(1'b0);
		end_test();

		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: all.f
+incdir+design
design/he_pixel_pkg.sv
design/he_ctrl_pkg.sv
design/he_ctrl.sv
design/he_key_shift.sv
design/he_rank_lane.sv
design/he_level_bank.sv
design/he_top.sv
dv/tb_clk_gen.sv
dv/tb_he_top.sv

// File: run.sh
#!/bin/sh
# Build and run the he_top testbench with Verilator.
# Exits non-zero if the build, the run or the testbench reports failure.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_he_top -f all.f --Mdir obj_dir -o sim_he_top
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_he_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
	echo "Testbench reported a failure, see $LOG"
	exit 1
fi

echo "Simulation finished cleanly, see $LOG"
exit 0
